// ==== files.f ====
+incdir+src
src/dp_pkg.sv
src/operand_if.sv
src/operand_stage.sv
src/reg_file.sv
src/function_unit.sv
src/data_mem.sv
src/execute_stage.sv
src/datapath_top.sv
tests/dp_checker.sv
tests/tb_datapath.sv

// ==== src/data_mem.sv ====
// data memory: word array with byte/half/word store lanes and combinational read
`timescale 1ns/1ps
`include "dp_macros.svh"

module data_mem (
    input  logic                              clk,
    input  logic                              arst_n,
    input  logic [$clog2(`DP_DMEM_WORDS)-1:0] addr,
    input  logic                              we,
    // size: 0 byte, 1 half, 2/3 word
    input  logic [1:0]                        strb,
    input  logic [1:0]                        byte_off,
    input  logic [`DP_XLEN-1:0]               wdata,
    output logic [`DP_XLEN-1:0]               rdata
);

    logic [`DP_XLEN-1:0] mem [0:`DP_DMEM_WORDS-1];
    logic [3:0]          lane_en;
    logic [`DP_XLEN-1:0] lane_data;

    // lanes touched by this store
    always_comb begin
        case (strb)
            2'd0:    lane_en = 4'b0001 << byte_off;
            2'd1:    lane_en = 4'b0011 << byte_off;
            default: lane_en = 4'b1111;
        endcase
    end

    // move store data up to its byte lane
    assign lane_data = wdata << {byte_off, 3'b000};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `DP_DMEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (we) begin
            for (int l = 0; l < 4; l++) begin
                if (lane_en[l]) begin
                    mem[addr][l*8 +: 8] <= lane_data[l*8 +: 8];
                end
            end
        end
    end

    // whole word, lane pick is done by the load path
    assign rdata = mem[addr];

endmodule

// ==== src/datapath_top.sv ====
// datapath top: operand stage, register file and execute stage
`timescale 1ns/1ps
`include "dp_macros.svh"

module datapath_top (
    input  logic                clk,
    input  logic                arst_n,
    // decoded instruction, one per cycle
    input  logic                issue,
    input  dp_pkg::inst_type_e  inst_type,
    input  logic [2:0]          fun3,
    input  logic                fun7,
    input  logic [4:0]          rd,
    input  logic [4:0]          rs1,
    input  logic [4:0]          rs2,
    input  logic [`DP_XLEN-1:0] pc,
    input  logic [`DP_XLEN-1:0] imm,
    // retire report, two edges after issue
    output logic                wb_valid,
    output logic [4:0]          wb_rd,
    output logic [`DP_XLEN-1:0] wb_data,
    output logic                br_valid,
    output logic                br_taken,
    output logic [3:0]          flags
);

    logic [4:0]          rs1_addr;
    logic [4:0]          rs2_addr;
    logic [`DP_XLEN-1:0] rs1_data;
    logic [`DP_XLEN-1:0] rs2_data;
    logic                rf_we;
    logic [4:0]          rf_waddr;
    logic [`DP_XLEN-1:0] rf_wdata;

    operand_if op_bus ();

    operand_stage u_operand (
        .clk       (clk),
        .arst_n    (arst_n),
        .issue     (issue),
        .inst_type (inst_type),
        .fun3      (fun3),
        .fun7      (fun7),
        .rd        (rd),
        .rs1       (rs1),
        .rs2       (rs2),
        .pc        (pc),
        .imm       (imm),
        .rs1_addr  (rs1_addr),
        .rs2_addr  (rs2_addr),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data),
        .rf_we     (rf_we),
        .rf_waddr  (rf_waddr),
        .rf_wdata  (rf_wdata),
        .op        (op_bus.producer)
    );

    reg_file u_regs (
        .clk      (clk),
        .arst_n   (arst_n),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .rf_we    (rf_we),
        .rf_waddr (rf_waddr),
        .rf_wdata (rf_wdata)
    );

    execute_stage u_execute (
        .clk      (clk),
        .arst_n   (arst_n),
        .op       (op_bus.consumer),
        .rf_we    (rf_we),
        .rf_waddr (rf_waddr),
        .rf_wdata (rf_wdata),
        .wb_valid (wb_valid),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data),
        .br_valid (br_valid),
        .br_taken (br_taken),
        .flags    (flags)
    );

endmodule

// ==== src/dp_macros.svh ====
// datapath macros: data width, register count and data memory depth
`ifndef DP_MACROS_SVH
`define DP_MACROS_SVH

// data path width in bits
`define DP_XLEN 32

// architectural registers, x0 included
`define DP_NREGS 32

// data memory depth in 32-bit words
// 128 words -> 7-bit word address, byte addresses 0..511
`define DP_DMEM_WORDS 128

`endif

// ==== src/dp_pkg.sv ====
// datapath package: instruction type and function unit opcode enums
package dp_pkg;

    // decoded instruction class from the control unit
    // encoding fixed by the control unit, load is 0 .. jal is 8
    typedef enum logic [3:0] {
        inst_load  = 4'd0,
        inst_imm   = 4'd1,
        inst_store = 4'd2,
        inst_reg   = 4'd3,
        inst_lui   = 4'd4,
        inst_auipc = 4'd5,
        inst_brnch = 4'd6,
        inst_jalr  = 4'd7,
        inst_jal   = 4'd8
    } inst_type_e;

    // function unit operations
    typedef enum logic [3:0] {
        alu_add    = 4'd0,
        alu_sub    = 4'd1,
        alu_sll    = 4'd2,
        alu_slt    = 4'd3,
        alu_sltu   = 4'd4,
        alu_xor    = 4'd5,
        alu_srl    = 4'd6,
        alu_sra    = 4'd7,
        alu_or     = 4'd8,
        alu_and    = 4'd9,
        alu_pass_b = 4'd10
    } alu_op_e;

endpackage

// ==== src/execute_stage.sv ====
// execute stage: ALU, load/store, branch resolve, writeback and retire registers
`timescale 1ns/1ps
`include "dp_macros.svh"

module execute_stage (
    input  logic                clk,
    input  logic                arst_n,
    operand_if.consumer         op,
    // register write port, combinational from the current instruction
    output logic                rf_we,
    output logic [4:0]          rf_waddr,
    output logic [`DP_XLEN-1:0] rf_wdata,
    // retire report
    output logic                wb_valid,
    output logic [4:0]          wb_rd,
    output logic [`DP_XLEN-1:0] wb_data,
    output logic                br_valid,
    output logic                br_taken,
    output logic [3:0]          flags
);
    import dp_pkg::*;

    localparam int AW = $clog2(`DP_DMEM_WORDS);

    alu_op_e             alu_op;
    logic [`DP_XLEN-1:0] alu_s;
    logic [3:0]          alu_zcnv;
    logic                is_load;
    logic                is_store;
    logic                is_brnch;
    logic [`DP_XLEN-1:0] mem_rdata;
    logic [`DP_XLEN-1:0] lane_data;
    logic [`DP_XLEN-1:0] load_data;
    logic                taken;

    assign is_load  = (op.inst_type == inst_load);
    assign is_store = (op.inst_type == inst_store);
    assign is_brnch = (op.inst_type == inst_brnch);

    // instruction type -> alu opcode
    always_comb begin
        case (op.inst_type)
            inst_lui:   alu_op = alu_pass_b;
            inst_brnch: alu_op = alu_sub;
            inst_reg, inst_imm: begin
                // fun7 picks sub over add and sra over srl
                case (op.fun3)
                    3'd0:    alu_op = op.fun7 ? alu_sub : alu_add;
                    3'd1:    alu_op = alu_sll;
                    3'd2:    alu_op = alu_slt;
                    3'd3:    alu_op = alu_sltu;
                    3'd4:    alu_op = alu_xor;
                    3'd5:    alu_op = op.fun7 ? alu_sra : alu_srl;
                    3'd6:    alu_op = alu_or;
                    default: alu_op = alu_and;
                endcase
            end
            // load, store, auipc, jal, jalr
            default:    alu_op = alu_add;
        endcase
    end

    function_unit u_fu (
        .a    (op.a),
        .b    (op.b),
        .op   (alu_op),
        .s    (alu_s),
        .zcnv (alu_zcnv)
    );

    // alu result is the byte address for loads and stores
    data_mem u_dmem (
        .clk      (clk),
        .arst_n   (arst_n),
        .addr     (alu_s[AW+1:2]),
        .we       (op.valid && is_store),
        .strb     (op.fun3[1:0]),
        .byte_off (alu_s[1:0]),
        .wdata    (op.store_data),
        .rdata    (mem_rdata)
    );

    // addressed byte/half down to bit 0, then extend
    // fun3[2] set means unsigned
    assign lane_data = mem_rdata >> {alu_s[1:0], 3'b000};

    always_comb begin
        case (op.fun3[1:0])
            2'd0:    load_data = {{(`DP_XLEN-8){lane_data[7] & ~op.fun3[2]}}, lane_data[7:0]};
            2'd1:    load_data = {{(`DP_XLEN-16){lane_data[15] & ~op.fun3[2]}}, lane_data[15:0]};
            default: load_data = lane_data;
        endcase
    end

    // branch condition from rs1 - rs2 flags
    always_comb begin
        case (op.fun3)
            3'd0:    taken = alu_zcnv[3];
            3'd1:    taken = ~alu_zcnv[3];
            3'd4:    taken = alu_zcnv[1] ^ alu_zcnv[0];
            3'd5:    taken = ~(alu_zcnv[1] ^ alu_zcnv[0]);
            3'd6:    taken = ~alu_zcnv[2];
            3'd7:    taken = alu_zcnv[2];
            default: taken = 1'b0;
        endcase
    end

    // every type but store and branch writes rd, x0 never
    assign rf_we    = op.valid && !is_store && !is_brnch && (op.rd != 5'd0);
    assign rf_waddr = op.rd;
    // link, lui and auipc results all come out of the alu
    assign rf_wdata = is_load ? load_data : alu_s;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_valid <= 1'b0;
            br_valid <= 1'b0;
            br_taken <= 1'b0;
            flags    <= 4'd0;
        end else begin
            wb_valid <= rf_we;
            br_valid <= op.valid && is_brnch;
            br_taken <= op.valid && is_brnch && taken;
            // flags hold between instructions
            if (op.valid) begin
                flags <= alu_zcnv;
            end
        end
    end

    // retire payload
    always_ff @(posedge clk) begin
        wb_rd   <= rf_waddr;
        wb_data <= rf_wdata;
    end

endmodule

// ==== src/function_unit.sv ====
// function unit: combinational ALU with result and zcnv flags
`timescale 1ns/1ps
`include "dp_macros.svh"

module function_unit (
    input  logic [`DP_XLEN-1:0] a,
    input  logic [`DP_XLEN-1:0] b,
    input  dp_pkg::alu_op_e     op,
    output logic [`DP_XLEN-1:0] s,
    output logic [3:0]          zcnv
);
    import dp_pkg::*;

    localparam int SHW = $clog2(`DP_XLEN);

    logic              is_sub;
    logic              is_arith;
    logic [`DP_XLEN-1:0] b_eff;
    logic [`DP_XLEN:0]   sum;
    logic [SHW-1:0]      shamt;

    assign is_sub   = (op == alu_sub);
    assign is_arith = (op == alu_add) || (op == alu_sub);
    assign shamt    = b[SHW-1:0];

    // subtract as a + ~b + 1, carry out is then "no borrow"
    assign b_eff = is_sub ? ~b : b;
    assign sum   = {1'b0, a} + {1'b0, b_eff} + {{`DP_XLEN{1'b0}}, is_sub};

    always_comb begin
        case (op)
            alu_add, alu_sub: s = sum[`DP_XLEN-1:0];
            alu_sll:          s = a << shamt;
            alu_slt:          s = {{(`DP_XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            alu_sltu:         s = {{(`DP_XLEN-1){1'b0}}, a < b};
            alu_xor:          s = a ^ b;
            alu_srl:          s = a >> shamt;
            alu_sra:          s = $unsigned($signed(a) >>> shamt);
            alu_or:           s = a | b;
            alu_and:          s = a & b;
            alu_pass_b:       s = b;
            default:          s = '0;
        endcase
    end

    // zero
    assign zcnv[3] = (s == '0);
    // carry, add/sub only
    assign zcnv[2] = is_arith & sum[`DP_XLEN];
    // negative
    assign zcnv[1] = s[`DP_XLEN-1];
    // signed overflow: same-sign inputs, result sign differs
    assign zcnv[0] = is_arith & (a[`DP_XLEN-1] == b_eff[`DP_XLEN-1])
                   & (sum[`DP_XLEN-1] != a[`DP_XLEN-1]);

endmodule

// ==== src/operand_if.sv ====
// operand bus: one registered instruction from the operand stage to execute
`timescale 1ns/1ps
`include "dp_macros.svh"

interface operand_if;
    import dp_pkg::*;

    // one-cycle level per instruction, no ready
    logic                valid;
    inst_type_e          inst_type;
    logic [2:0]          fun3;
    logic                fun7;
    logic [4:0]          rd;
    // function unit operands
    logic [`DP_XLEN-1:0] a;
    logic [`DP_XLEN-1:0] b;
    // rs2 value kept for stores
    logic [`DP_XLEN-1:0] store_data;

    modport producer (
        output valid, inst_type, fun3, fun7, rd, a, b, store_data
    );

    modport consumer (
        input valid, inst_type, fun3, fun7, rd, a, b, store_data
    );

endinterface

// ==== src/operand_stage.sv ====
// operand stage: register read with bypass, operand select and pipeline register
`timescale 1ns/1ps
`include "dp_macros.svh"

module operand_stage (
    input  logic                clk,
    input  logic                arst_n,
    // decoded instruction from the control unit
    input  logic                issue,
    input  dp_pkg::inst_type_e  inst_type,
    input  logic [2:0]          fun3,
    input  logic                fun7,
    input  logic [4:0]          rd,
    input  logic [4:0]          rs1,
    input  logic [4:0]          rs2,
    input  logic [`DP_XLEN-1:0] pc,
    input  logic [`DP_XLEN-1:0] imm,
    // register file read ports
    output logic [4:0]          rs1_addr,
    output logic [4:0]          rs2_addr,
    input  logic [`DP_XLEN-1:0] rs1_data,
    input  logic [`DP_XLEN-1:0] rs2_data,
    // write port of the instruction in execute, for bypass
    input  logic                rf_we,
    input  logic [4:0]          rf_waddr,
    input  logic [`DP_XLEN-1:0] rf_wdata,
    operand_if.producer         op
);
    import dp_pkg::*;

    logic [`DP_XLEN-1:0] rs1_val;
    logic [`DP_XLEN-1:0] rs2_val;
    logic [`DP_XLEN-1:0] a_sel;
    logic [`DP_XLEN-1:0] b_sel;

    assign rs1_addr = rs1;
    assign rs2_addr = rs2;

    // execute writes at the same edge we sample, so forward its data
    assign rs1_val = (rf_we && rf_waddr != 5'd0 && rf_waddr == rs1) ? rf_wdata : rs1_data;
    assign rs2_val = (rf_we && rf_waddr != 5'd0 && rf_waddr == rs2) ? rf_wdata : rs2_data;

    always_comb begin
        // operand a: pc for pc-relative and link types
        case (inst_type)
            inst_auipc, inst_jalr, inst_jal: a_sel = pc;
            default:                         a_sel = rs1_val;
        endcase

        // operand b
        case (inst_type)
            // branch compare needs rs2
            inst_reg, inst_brnch: b_sel = rs2_val;
            // link value is pc + 4
            inst_jal, inst_jalr:  b_sel = `DP_XLEN'd4;
            default:              b_sel = imm;
        endcase
    end

    // valid only
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            op.valid <= 1'b0;
        end else begin
            op.valid <= issue;
        end
    end

    // operand payload
    always_ff @(posedge clk) begin
        op.inst_type  <= inst_type;
        op.fun3       <= fun3;
        op.fun7       <= fun7;
        op.rd         <= rd;
        op.a          <= a_sel;
        op.b          <= b_sel;
        op.store_data <= rs2_val;
    end

endmodule

// ==== src/reg_file.sv ====
// register file: 32 entries, two combinational reads, one clocked write
`timescale 1ns/1ps
`include "dp_macros.svh"

module reg_file (
    input  logic                clk,
    input  logic                arst_n,
    input  logic [4:0]          rs1_addr,
    input  logic [4:0]          rs2_addr,
    output logic [`DP_XLEN-1:0] rs1_data,
    output logic [`DP_XLEN-1:0] rs2_data,
    input  logic                rf_we,
    input  logic [4:0]          rf_waddr,
    input  logic [`DP_XLEN-1:0] rf_wdata
);

    // x0 has no storage
    logic [`DP_XLEN-1:0] regs [1:`DP_NREGS-1];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < `DP_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (rf_we && rf_waddr != 5'd0) begin
            regs[rf_waddr] <= rf_wdata;
        end
    end

    // x0 reads zero
    assign rs1_data = (rs1_addr == 5'd0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == 5'd0) ? '0 : regs[rs2_addr];

endmodule

// ==== tests/dp_checker.sv ====
// retire checker: compares DUT retire ports with queued model records
`timescale 1ns/1ps
`include "dp_macros.svh"

module dp_checker (
    input  logic                clk,
    // DUT retire ports
    input  logic                wb_valid,
    input  logic [4:0]          wb_rd,
    input  logic [`DP_XLEN-1:0] wb_data,
    input  logic                br_valid,
    input  logic                br_taken,
    input  logic [3:0]          flags,
    // expected record, sampled with issue
    input  logic                exp_push,
    input  logic                exp_wb,
    input  logic [4:0]          exp_rd,
    input  logic [`DP_XLEN-1:0] exp_data,
    input  logic                exp_br,
    input  logic                exp_taken,
    input  logic [3:0]          exp_flags,
    output int                  errors,
    output int                  checked
);

    typedef struct packed {
        logic [31:0]         due;
        logic                wb;
        logic [4:0]          rd;
        logic [`DP_XLEN-1:0] data;
        logic                br;
        logic                taken;
        logic [3:0]          flags;
    } exp_rec_t;

    exp_rec_t    exp_q [$];
    exp_rec_t    cur;
    logic [31:0] cycle = 0;
    logic [3:0]  last_flags = 4'd0;
    int          err_cnt = 0;
    int          done_cnt = 0;

    assign errors  = err_cnt;
    assign checked = done_cnt;

    task check_val(input string name, input logic [31:0] expv, input logic [31:0] actv);
        if (expv !== actv) begin
            err_cnt++;
            $display("[ERROR] %0t %s expected %h actual %h", $time, name, expv, actv);
        end
    endtask

    // issue edge loads the operand register, the next edge loads the retire outputs
    // so the record is due in the cycle after the following edge
    always @(posedge clk) begin
        cycle = cycle + 1;
        if (exp_push) begin
            exp_q.push_back({cycle + 32'd1, exp_wb, exp_rd, exp_data, exp_br, exp_taken,
                             exp_flags});
        end
    end

    // outputs settle after the rising edge, compare mid-cycle
    always @(negedge clk) begin
        if (exp_q.size() > 0 && exp_q[0].due == cycle) begin
            cur = exp_q.pop_front();
            done_cnt++;
            if ((cur.wb || cur.br) && !wb_valid && !br_valid) begin
                err_cnt++;
                $display("missing retire at %0t, expected one for rd %0d", $time, cur.rd);
            end else begin
                check_val("wb_valid", cur.wb, wb_valid);
                if (cur.wb) begin
                    check_val("wb_rd", cur.rd, wb_rd);
                    check_val("wb_data", cur.data, wb_data);
                end
                check_val("br_valid", cur.br, br_valid);
                if (cur.br) begin
                    check_val("br_taken", cur.taken, br_taken);
                end
            end
            check_val("flags", cur.flags, flags);
            last_flags = cur.flags;
        end else begin
            if (wb_valid || br_valid) begin
                err_cnt++;
                $display("retire at %0t with no expected record", $time);
            end
            // flags hold between instructions, zero after reset
            check_val("flags", last_flags, flags);
        end
    end

endmodule

// ==== tests/tb_datapath.sv ====
// datapath testbench: random decoded instructions checked against a reference model
`timescale 1ns/1ps
`include "dp_macros.svh"

module tb_datapath;
    import dp_pkg::*;

    localparam int N_INST = 600;
    // 600 / 0.8 issue rate, plus reset and margin
    localparam int TIMEOUT_CYCLES = 1000;

    logic clk;
    logic arst_n;
    logic issue;
    inst_type_e inst_type;
    logic [2:0] fun3;
    logic fun7;
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic [`DP_XLEN-1:0] pc;
    logic [`DP_XLEN-1:0] imm;
    logic wb_valid;
    logic [4:0] wb_rd;
    logic [`DP_XLEN-1:0] wb_data;
    logic br_valid;
    logic br_taken;
    logic [3:0] flags;
    // model output toward the checker
    logic exp_push;
    logic exp_wb;
    logic [4:0] exp_rd;
    logic [`DP_XLEN-1:0] exp_data;
    logic exp_br;
    logic exp_taken;
    logic [3:0] exp_flags;
    int errors;
    int checked;
    int issued;
    int cycles;
    logic [4:0] last_rd;
    logic [31:0] lcg_state = 32'd12612;
    // model state
    logic [`DP_XLEN-1:0] regs [0:`DP_NREGS-1];
    logic [`DP_XLEN-1:0] mem [0:`DP_DMEM_WORDS-1];

    datapath_top dut (
        .clk(clk), .arst_n(arst_n), .issue(issue), .inst_type(inst_type),
        .fun3(fun3), .fun7(fun7), .rd(rd), .rs1(rs1), .rs2(rs2), .pc(pc), .imm(imm),
        .wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data),
        .br_valid(br_valid), .br_taken(br_taken), .flags(flags)
    );

    dp_checker chk (
        .clk(clk), .wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data),
        .br_valid(br_valid), .br_taken(br_taken), .flags(flags),
        .exp_push(exp_push), .exp_wb(exp_wb), .exp_rd(exp_rd), .exp_data(exp_data),
        .exp_br(exp_br), .exp_taken(exp_taken), .exp_flags(exp_flags),
        .errors(errors), .checked(checked)
    );

    // lcg, upper bits folded down since the low bits cycle quickly
    function logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state ^ (lcg_state >> 16);
    endfunction

    // reg/imm result from fun3, fun7 picks sub and sra
    function automatic logic [31:0] ref_alu(input logic [31:0] a, input logic [31:0] b,
                                            input logic [2:0] f3, input logic f7);
        case (f3)
            3'd0:    return f7 ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3:    return (a < b) ? 32'd1 : 32'd0;
            3'd4:    return a ^ b;
            3'd5:    return f7 ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    // zcnv, mode 0 logic/pass, 1 add, 2 sub
    function automatic logic [3:0] ref_flags(input logic [31:0] a, input logic [31:0] b,
                                             input logic [31:0] s, input int mode);
        logic [32:0] wide;
        logic c;
        logic v;
        wide = {1'b0, a} + {1'b0, b};
        c = (mode == 1) ? wide[32] : (mode == 2) ? (a >= b) : 1'b0;
        v = (mode == 1) ? (a[31] == b[31] && s[31] != a[31])
          : (mode == 2) ? (a[31] != b[31] && s[31] != a[31]) : 1'b0;
        return {s == 32'd0, c, s[31], v};
    endfunction

    task gen_instr();
        int sel;
        inst_type = inst_type_e'(next_rand() % 9);
        fun3 = next_rand() % 8;
        fun7 = next_rand() % 2;
        rd = next_rand() % 8;
        // small register range plus reuse of last rd for dependences
        rs1 = (next_rand() % 4 == 0) ? last_rd : next_rand() % 8;
        sel = next_rand() % 8;
        rs2 = (sel < 2) ? last_rd : (sel < 4) ? rs1 : next_rand() % 8;
        pc = next_rand() & 32'hffff_fffc;
        imm = next_rand();
        case (inst_type)
            inst_load, inst_store: begin
                rs1 = 5'd0;
                sel = next_rand() % 5;
                if (inst_type == inst_store) begin
                    fun3 = sel % 3;
                end else begin
                    fun3 = (sel < 3) ? sel : sel + 1;
                end
                // aligned, low words so loads hit earlier stores
                imm = (next_rand() % 64) & ~((32'd1 << fun3[1:0]) - 1);
            end
            inst_brnch: begin
                sel = next_rand() % 6;
                fun3 = (sel < 2) ? sel : sel + 2;
            end
            default: ;
        endcase
        last_rd = rd;
    endtask

    task model_issue();
        logic [31:0] v1;
        logic [31:0] v2;
        logic [31:0] res;
        logic [31:0] lane;
        logic [3:0] f;
        logic wb;
        logic taken;
        int w;
        int off;
        v1 = regs[rs1];
        v2 = regs[rs2];
        wb = (inst_type != inst_store) && (inst_type != inst_brnch);
        taken = 1'b0;
        res = 32'd0;
        w = imm[8:2];
        off = imm[1:0];
        case (inst_type)
            inst_load: begin
                lane = mem[w] >> (8 * off);
                case (fun3)
                    3'd0:    res = {{24{lane[7]}}, lane[7:0]};
                    3'd4:    res = {24'd0, lane[7:0]};
                    3'd1:    res = {{16{lane[15]}}, lane[15:0]};
                    3'd5:    res = {16'd0, lane[15:0]};
                    default: res = lane;
                endcase
                f = ref_flags(32'd0, imm, imm, 1);
            end
            inst_store: begin
                case (fun3)
                    3'd0:    mem[w][8*off +: 8] = v2[7:0];
                    3'd1:    mem[w][8*off +: 16] = v2[15:0];
                    default: mem[w] = v2;
                endcase
                f = ref_flags(32'd0, imm, imm, 1);
            end
            inst_lui: begin
                res = imm;
                f = ref_flags(v1, imm, imm, 0);
            end
            inst_auipc: begin
                res = pc + imm;
                f = ref_flags(pc, imm, res, 1);
            end
            inst_jal, inst_jalr: begin
                res = pc + 32'd4;
                f = ref_flags(pc, 32'd4, res, 1);
            end
            inst_brnch: begin
                f = ref_flags(v1, v2, v1 - v2, 2);
                case (fun3)
                    3'd0:    taken = (v1 == v2);
                    3'd1:    taken = (v1 != v2);
                    3'd4:    taken = ($signed(v1) < $signed(v2));
                    3'd5:    taken = ($signed(v1) >= $signed(v2));
                    3'd6:    taken = (v1 < v2);
                    default: taken = (v1 >= v2);
                endcase
            end
            default: begin
                // reg takes rs2, imm takes the immediate
                if (inst_type == inst_reg) begin
                    v2 = regs[rs2];
                end else begin
                    v2 = imm;
                end
                res = ref_alu(v1, v2, fun3, fun7);
                f = ref_flags(v1, v2, res, (fun3 != 3'd0) ? 0 : (fun7 ? 2 : 1));
            end
        endcase
        wb = wb && (rd != 5'd0);
        if (wb) begin
            regs[rd] = res;
        end
        exp_wb = wb;
        exp_rd = rd;
        exp_data = res;
        exp_br = (inst_type == inst_brnch);
        exp_taken = taken;
        exp_flags = f;
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        arst_n = 1'b0;
        issue = 1'b0;
        inst_type = inst_load;
        fun3 = 3'd0;
        fun7 = 1'b0;
        rd = 5'd0;
        rs1 = 5'd0;
        rs2 = 5'd0;
        pc = '0;
        imm = '0;
        exp_push = 1'b0;
        exp_wb = 1'b0;
        exp_rd = 5'd0;
        exp_data = '0;
        exp_br = 1'b0;
        exp_taken = 1'b0;
        exp_flags = 4'd0;
        last_rd = 5'd0;
        issued = 0;
        for (int i = 0; i < `DP_NREGS; i++) begin
            regs[i] = '0;
        end
        for (int i = 0; i < `DP_DMEM_WORDS; i++) begin
            mem[i] = '0;
        end
        repeat (10) @(posedge clk);
        #2;
        arst_n = 1'b1;
        // issue on roughly 80 percent of cycles
        while (issued < N_INST) begin
            @(posedge clk);
            #2;
            if (next_rand() % 10 < 8) begin
                gen_instr();
                model_issue();
                issue = 1'b1;
                exp_push = 1'b1;
                issued++;
            end else begin
                issue = 1'b0;
                exp_push = 1'b0;
            end
        end
        @(posedge clk);
        #2;
        issue = 1'b0;
        exp_push = 1'b0;
        wait (checked == N_INST);
        @(posedge clk);
        $display("checked %0d of %0d instructions, errors %0d", checked, N_INST, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    // run limit
    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles, only %0d of %0d instructions retired",
                 cycles, checked, N_INST);
        $display("sim failed");
        $finish;
    end

endmodule
